/* common/audio_pkg.sv */
// ==========================================================================
// audio engine shared definitions
// sizes, host bus memory map, sample and stereo types, and the bus and
// RAM write structs used between the register block and the RAMs
// ==========================================================================

package audio_pkg;

    // storage sizes
    localparam int CHANNELS = 8;
    localparam int FRAMES   = 64;
    localparam int CODE     = 256;
    localparam int CHAN_W   = 3;
    localparam int FRAME_W  = 6;
    localparam int CODE_W   = 8;
    localparam int AUDIO    = CHANNELS * FRAMES;
    localparam int AUDIO_W  = 9;

    // window base, compared against addr[31:16]
    localparam logic [15:0] BUS_BASE = 16'h6000;

    // byte offsets inside the window, decoded from addr[12:10]
    localparam logic [15:0] REG_COEF   = 16'h0000;
    localparam logic [15:0] REG_RESULT = 16'h0400;
    localparam logic [15:0] REG_STATUS = 16'h0800;
    localparam logic [15:0] REG_RUN    = 16'h0C00;
    localparam logic [15:0] REG_AUDIO  = 16'h1000;

    // ck cycles per sck half period
    localparam int I2S_DIV = 2;

    typedef logic signed [15:0] sample_t;

    typedef struct packed {
        sample_t left;
        sample_t right;
    } stereo_t;

    typedef struct packed {
        logic        valid;
        logic [3:0]  wstrb;
        logic [31:0] addr;
        logic [31:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic        ready;
        logic [31:0] rdata;
    } bus_rsp_t;

    // one-cycle write into either RAM
    typedef struct packed {
        logic               we;
        logic [AUDIO_W-1:0] addr;
        logic [31:0]        data;
    } mem_wr_t;

endpackage

/* common/seq_pkg.sv */
// ==========================================================================
// sequencer definitions
// opcodes, FSM states, the program word layout and the command word
// passed from the sequencer to the MAC unit
// ==========================================================================

package seq_pkg;

    // accumulator width
    localparam int ACC_W = 40;

    // any other encoding is illegal and stops the run with error
    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_CLR  = 4'h1,
        OP_MAC  = 4'h2,
        OP_SAVE = 4'h3,
        OP_HALT = 4'h4
    } opcode_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_DECODE,
        S_EXEC,
        S_DONE
    } seq_state_t;

    // program word, op in bits 31:28 and gain in bits 15:0
    typedef struct packed {
        opcode_t             op;
        logic [2:0]          chan;
        logic [5:0]          offset;
        logic                side;
        logic [1:0]          pad;
        audio_pkg::sample_t  gain;
    } instr_t;

    typedef struct packed {
        logic                clr;
        logic                acc;
        logic                save;
        logic                side;
        audio_pkg::sample_t  gain;
    } mac_cmd_t;

endpackage

/* design/dpram.sv */
// ==========================================================================
// dual-port RAM
// one synchronous write port and one registered read port
// ==========================================================================

`timescale 1ns/1ps

module dpram #(
    parameter int BITS = 16,
    parameter int SIZE = 256
) (
    input  logic                    ck,
    input  logic                    we,
    input  logic [$clog2(SIZE)-1:0] waddr,
    input  logic [BITS-1:0]         wdata,
    input  logic [$clog2(SIZE)-1:0] raddr,
    output logic [BITS-1:0]         rdata
);

    logic [BITS-1:0] mem [SIZE];

    // same-address read during a write sees the old word
    always_ff @(posedge ck) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];
    end

endmodule

/* design/bus_regs.sv */
// ==========================================================================
// host bus register block
// decodes the peripheral window, answers each request with a single
// ready pulse, holds the frame register, routes RAM writes and reads
// back status, frame and result words
// ==========================================================================

`timescale 1ns/1ps

module bus_regs (
    input  logic                          ck,
    input  logic                          rst,
    input  audio_pkg::bus_req_t           req,
    output audio_pkg::bus_rsp_t           rsp,
    output audio_pkg::mem_wr_t            coef_wr,
    output audio_pkg::mem_wr_t            audio_wr,
    output logic [audio_pkg::FRAME_W-1:0] frame,
    output logic                          run,
    input  logic                          busy,
    input  logic                          done,
    input  logic                          error,
    input  audio_pkg::stereo_t            result
);

    import audio_pkg::*;

    logic               hit;
    logic               accept;
    logic               is_write;
    logic               wr_hit;
    logic               is_coef;
    logic               is_result;
    logic               is_status;
    logic               is_run;
    logic               is_audio;
    logic               ready_q;
    logic [31:0]        rdata_q;
    logic [31:0]        rd_mux;
    logic               coef_we_q;
    logic               audio_we_q;
    logic [AUDIO_W-1:0] wr_addr;
    logic [31:0]        wr_data;

    assign hit      = req.valid && (req.addr[31:16] == BUS_BASE);
    // a request still held during its ready cycle is not taken again
    assign accept   = hit && !ready_q;
    assign is_write = |req.wstrb;
    assign wr_hit   = accept && is_write;

    assign is_coef   = req.addr[12:10] == REG_COEF[12:10];
    assign is_result = req.addr[12:10] == REG_RESULT[12:10];
    assign is_status = req.addr[12:10] == REG_STATUS[12:10];
    assign is_run    = req.addr[12:10] == REG_RUN[12:10];
    // audio spans two 1k blocks
    assign is_audio  = req.addr[12] == REG_AUDIO[12];

    always_comb begin
        rd_mux = '0;
        if (is_status) begin
            if (req.addr[2]) begin
                rd_mux = 32'(frame);
            end else begin
                rd_mux = {29'b0, busy, error, done};
            end
        end else if (is_result) begin
            rd_mux = req.addr[2] ? 32'(result.right) : 32'(result.left);
        end
    end

    always_ff @(posedge ck) begin
        if (rst) begin
            ready_q    <= 1'b0;
            rdata_q    <= '0;
            coef_we_q  <= 1'b0;
            audio_we_q <= 1'b0;
            run        <= 1'b0;
            frame      <= '0;
        end else begin
            ready_q    <= accept;
            // read data only alongside ready
            rdata_q    <= (accept && !is_write) ? rd_mux : '0;
            coef_we_q  <= wr_hit && is_coef;
            audio_we_q <= wr_hit && is_audio;
            run        <= wr_hit && is_run;
            if (wr_hit && is_status && req.addr[2]) begin
                frame <= req.wdata[FRAME_W-1:0];
            end
        end
    end

    // shared write payload
    always_ff @(posedge ck) begin
        if (accept) begin
            wr_addr <= req.addr[AUDIO_W+1:2];
            wr_data <= req.wdata;
        end
    end

    assign coef_wr = '{we: coef_we_q,
                       addr: {{(AUDIO_W-CODE_W){1'b0}}, wr_addr[CODE_W-1:0]},
                       data: wr_data};
    assign audio_wr = '{we: audio_we_q, addr: wr_addr, data: {16'b0, wr_data[15:0]}};

    assign rsp = '{ready: ready_q, rdata: rdata_q};

endmodule

/* sequencer/sequencer.sv */
// ==========================================================================
// program sequencer
// fetches program words, decodes them, addresses the sample RAM and
// issues clear, accumulate and save commands to the MAC unit
// ==========================================================================

`timescale 1ns/1ps

module sequencer (
    input  logic                          ck,
    input  logic                          rst,
    input  logic                          run,
    input  logic [audio_pkg::FRAME_W-1:0] frame,
    output logic [audio_pkg::CODE_W-1:0]  coef_raddr,
    input  logic [31:0]                   coef_rdata,
    output logic [audio_pkg::AUDIO_W-1:0] audio_raddr,
    output seq_pkg::mac_cmd_t             mac,
    output logic                          busy,
    output logic                          done,
    output logic                          error
);

    import audio_pkg::*;
    import seq_pkg::*;

    seq_state_t         state;
    logic [CODE_W-1:0]  pc;
    logic               fetch_wait;
    instr_t             instr;
    logic [FRAME_W-1:0] src_frame;

    assign coef_raddr = pc;

    // frames back from the current one, wrapping modulo 64
    assign src_frame   = frame - instr.offset;
    assign audio_raddr = {instr.chan, src_frame};

    // second fetch cycle has the program word
    always_ff @(posedge ck) begin
        if (state == S_FETCH && fetch_wait) begin
            instr <= instr_t'(coef_rdata);
        end
    end

    always_ff @(posedge ck) begin
        if (rst) begin
            state      <= S_IDLE;
            pc         <= '0;
            fetch_wait <= 1'b0;
            busy       <= 1'b0;
            done       <= 1'b0;
            error      <= 1'b0;
            mac        <= '0;
        end else begin
            mac <= '0;
            case (state)
                S_IDLE, S_DONE: begin
                    if (run) begin
                        state      <= S_FETCH;
                        pc         <= '0;
                        fetch_wait <= 1'b0;
                        busy       <= 1'b1;
                        done       <= 1'b0;
                        error      <= 1'b0;
                        mac.clr    <= 1'b1;
                    end
                end
                S_FETCH: begin
                    fetch_wait <= ~fetch_wait;
                    if (fetch_wait) begin
                        state <= S_DECODE;
                    end
                end
                S_DECODE: begin
                    // command lands together with the sample
                    mac.side <= instr.side;
                    mac.gain <= instr.gain;
                    state    <= S_EXEC;
                    case (instr.op)
                        OP_NOP: ;
                        OP_CLR:  mac.clr  <= 1'b1;
                        OP_MAC:  mac.acc  <= 1'b1;
                        OP_SAVE: mac.save <= 1'b1;
                        OP_HALT: begin
                            done  <= 1'b1;
                            busy  <= 1'b0;
                            state <= S_DONE;
                        end
                        default: begin
                            error <= 1'b1;
                            busy  <= 1'b0;
                            state <= S_DONE;
                        end
                    endcase
                end
                S_EXEC: begin
                    // wraps past the last word
                    pc    <= pc + 1'b1;
                    state <= S_FETCH;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

/* sequencer/mac_unit.sv */
// ==========================================================================
// multiply-accumulate unit
// 40-bit signed accumulator of sample times gain, with rounding and
// saturation into the stereo result register on save
// ==========================================================================

`timescale 1ns/1ps

module mac_unit (
    input  logic               ck,
    input  logic               rst,
    input  seq_pkg::mac_cmd_t  mac,
    input  audio_pkg::sample_t sample,
    output audio_pkg::stereo_t result
);

    import audio_pkg::*;
    import seq_pkg::*;

    logic signed [ACC_W-1:0] acc;
    logic signed [31:0]      product;
    logic signed [ACC_W:0]   rounded;
    logic signed [ACC_W:0]   scaled;
    sample_t                 sat;

    assign product = sample * mac.gain;

    // Q15 scaling, half an LSB rounds up
    assign rounded = $signed({acc[ACC_W-1], acc}) + 16384;
    assign scaled  = rounded >>> 15;

    always_comb begin
        if (scaled > 32767) begin
            sat = 16'h7fff;
        end else if (scaled < -32768) begin
            sat = 16'h8000;
        end else begin
            sat = scaled[15:0];
        end
    end

    always_ff @(posedge ck) begin
        if (mac.clr) begin
            acc <= '0;
        end else if (mac.acc) begin
            acc <= acc + product;
        end
    end

    always_ff @(posedge ck) begin
        if (rst) begin
            result <= '0;
        end else if (mac.save) begin
            if (mac.side) begin
                result.right <= sat;
            end else begin
                result.left <= sat;
            end
        end
    end

endmodule

/* i2s/i2s_out.sv */
// ==========================================================================
// I2S transmitter
// divides ck down to sck, counts 64 sck periods per frame for ws and
// shifts the stereo result out MSB first with the standard 1-bit delay
// ==========================================================================

`timescale 1ns/1ps

module i2s_out (
    input  logic               ck,
    input  logic               rst,
    input  audio_pkg::stereo_t result,
    output logic               sck,
    output logic               ws,
    output logic               sd
);

    import audio_pkg::*;

    logic [$clog2(I2S_DIV)-1:0] div_cnt;
    logic                       tick;
    logic                       fall;
    logic [5:0]                 posn;
    logic [63:0]                shreg;

    assign tick = int'(div_cnt) == I2S_DIV - 1;
    // sck about to go low
    assign fall = tick && sck;

    // low half of the frame is left
    assign ws = posn[5];
    assign sd = shreg[63];

    always_ff @(posedge ck) begin
        if (rst) begin
            div_cnt <= '0;
            sck     <= 1'b0;
            posn    <= '0;
            shreg   <= '0;
        end else begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            if (tick) begin
                sck <= ~sck;
            end
            if (fall) begin
                posn <= posn + 1'b1;
                if (posn == 6'd63) begin
                    // MSB goes out one period after the ws change
                    shreg <= {1'b0, result.left, 16'b0, result.right, 15'b0};
                end else begin
                    shreg <= {shreg[62:0], 1'b0};
                end
            end
        end
    end

endmodule

/* design/audio_engine.sv */
// ==========================================================================
// audio mixing peripheral, top level
// host register block, program and sample RAMs, sequencer, MAC unit
// and I2S transmitter
// ==========================================================================

`timescale 1ns/1ps

module audio_engine (
    input  logic                ck,
    input  logic                rst,
    input  audio_pkg::bus_req_t req,
    output audio_pkg::bus_rsp_t rsp,
    output logic                sck,
    output logic                ws,
    output logic                sd
);

    import audio_pkg::*;
    import seq_pkg::*;

    mem_wr_t            coef_wr;
    mem_wr_t            audio_wr;
    logic [FRAME_W-1:0] frame;
    logic               run;
    logic               busy;
    logic               done;
    logic               error;
    stereo_t            result;
    logic [CODE_W-1:0]  coef_raddr;
    logic [31:0]        coef_rdata;
    logic [AUDIO_W-1:0] audio_raddr;
    sample_t            audio_rdata;
    mac_cmd_t           mac;

    bus_regs u_regs (
        .ck(ck), .rst(rst), .req(req), .rsp(rsp),
        .coef_wr(coef_wr), .audio_wr(audio_wr),
        .frame(frame), .run(run),
        .busy(busy), .done(done), .error(error),
        .result(result)
    );

    // program words
    dpram #(.BITS(32), .SIZE(CODE)) u_coef (
        .ck(ck), .we(coef_wr.we), .waddr(coef_wr.addr[CODE_W-1:0]),
        .wdata(coef_wr.data), .raddr(coef_raddr), .rdata(coef_rdata)
    );

    // samples, channel * 64 + frame
    dpram #(.BITS(16), .SIZE(AUDIO)) u_audio (
        .ck(ck), .we(audio_wr.we), .waddr(audio_wr.addr),
        .wdata(audio_wr.data[15:0]), .raddr(audio_raddr), .rdata(audio_rdata)
    );

    sequencer u_seq (
        .ck(ck), .rst(rst), .run(run), .frame(frame),
        .coef_raddr(coef_raddr), .coef_rdata(coef_rdata),
        .audio_raddr(audio_raddr), .mac(mac),
        .busy(busy), .done(done), .error(error)
    );

    mac_unit u_mac (
        .ck(ck), .rst(rst), .mac(mac), .sample(audio_rdata), .result(result)
    );

    i2s_out u_i2s (
        .ck(ck), .rst(rst), .result(result), .sck(sck), .ws(ws), .sd(sd)
    );

endmodule

/* test/audio_model.svh */
// ==========================================================================
// reference model of the mixing engine
// copies of both RAMs and the frame register, a program interpreter with
// wrap-around, rounding and saturation, and a Galois LFSR random source
// ==========================================================================

`ifndef AUDIO_MODEL_SVH
`define AUDIO_MODEL_SVH

// bound on interpreted words, well past one full wrap
localparam int MODEL_STEPS = 4096;

logic [31:0]        m_coef [256];
logic [15:0]        m_audio [512];
logic [5:0]         m_frame;
logic signed [15:0] m_left;
logic signed [15:0] m_right;
logic               m_done;
logic               m_error;
logic [31:0]        lfsr_state;

// one LFSR step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        b;
    v = '0;
    for (int i = 0; i < n; i++) begin
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ 32'hd0000001;
        end
        v = {v[30:0], b};
    end
    return v;
endfunction

function automatic logic [31:0] make_instr(input logic [3:0] op, input logic [2:0] chan,
                                           input logic [5:0] offset, input logic side,
                                           input logic [15:0] gain);
    return {op, chan, offset, side, 2'b00, gain};
endfunction

// Q15 back to 16 bits, half an LSB rounds up, then clamp
function automatic logic [15:0] scale_sat(input longint acc);
    longint s;
    s = (acc + 64'sd16384) >>> 15;
    if (s > 64'sd32767) begin
        return 16'h7fff;
    end else if (s < -64'sd32768) begin
        return 16'h8000;
    end
    return s[15:0];
endfunction

task automatic model_run();
    int          pc;
    int          steps;
    longint      acc;
    logic [31:0] w;
    logic [5:0]  src;
    logic [15:0] smp;
    pc = 0;
    steps = 0;
    acc = 0;
    m_done = 1'b0;
    m_error = 1'b0;
    while (!m_done && !m_error && steps < MODEL_STEPS) begin
        w = m_coef[pc];
        // frames back from the current one, modulo 64
        src = 6'(m_frame - w[24:19]);
        smp = m_audio[{w[27:25], src}];
        case (w[31:28])
            OP_NOP: ;
            OP_CLR: acc = 0;
            OP_MAC: acc = acc + longint'($signed(smp)) * longint'($signed(w[15:0]));
            OP_SAVE: begin
                if (w[18]) begin
                    m_right = scale_sat(acc);
                end else begin
                    m_left = scale_sat(acc);
                end
            end
            OP_HALT: m_done = 1'b1;
            default: m_error = 1'b1;
        endcase
        pc = (pc + 1) % 256;
        steps++;
    end
endtask

`endif

/* test/tb_audio_engine.sv */
// ==========================================================================
// audio engine testbench
// loads samples and mixing programs over the host bus, runs them, checks
// status and results against a reference model and decodes the I2S line
// ==========================================================================

`timescale 1ns/1ps

module tb_audio_engine;

    import audio_pkg::*;
    import seq_pkg::*;

    localparam logic [31:0] SEED     = 32'ha39f673f;
    localparam logic [31:0] BASE     = {BUS_BASE, 16'h0000};
    localparam int          RUNS     = 16;
    localparam int          PROG_MAX = 256;
    localparam int          POLL_MAX = PROG_MAX * 4;
    // ck cycles in one I2S frame
    localparam int          FRAME_CK = 64 * 2 * I2S_DIV;
    localparam int          WATCH_CK = 2 * (RUNS * PROG_MAX * 4 + 4 * FRAME_CK
                                            + (AUDIO + RUNS * 64) * 4);

    logic     ck;
    logic     rst;
    bus_req_t req;
    bus_rsp_t rsp;
    logic     sck;
    logic     ws;
    logic     sd;

    int          errors;
    int          checks;
    int          test_errors;
    int          tests_run;
    logic [31:0] prog [$];

    // I2S capture state
    int          bit_idx = 64;
    logic        ws_prev = 1'b0;
    logic        have_left = 1'b0;
    logic [15:0] shift_word;
    logic [15:0] left_word;
    logic [15:0] cap_left;
    logic [15:0] cap_right;
    int          frames_seen = 0;

    // ck cycles spent in each ws half
    int          half_ck = 0;
    int          bad_halves = 0;
    logic        ws_last = 1'b0;

    `include "audio_model.svh"

    audio_engine u_dut (
        .ck(ck), .rst(rst), .req(req), .rsp(rsp), .sck(sck), .ws(ws), .sd(sd)
    );

    always #4 ck = ~ck;

    // word bits follow the one-period delay after each ws change
    always @(posedge sck) begin
        if (ws !== ws_prev) begin
            bit_idx = 0;
        end else if (bit_idx < 64) begin
            bit_idx++;
        end
        ws_prev = ws;
        if (bit_idx >= 1 && bit_idx <= 16) begin
            shift_word = {shift_word[14:0], sd};
        end
        if (bit_idx == 16) begin
            if (!ws) begin
                left_word = shift_word;
                have_left = 1'b1;
            end else if (have_left) begin
                cap_left = left_word;
                cap_right = shift_word;
                frames_seen++;
            end
        end
    end

    // each half of an I2S frame lasts 32 sck periods
    always @(negedge ck) begin
        if (ws !== ws_last) begin
            if (half_ck != 0 && half_ck != FRAME_CK / 2) begin
                bad_halves++;
            end
            half_ck = 1;
        end else if (half_ck != 0) begin
            half_ck++;
        end
        ws_last = ws;
    end

    task automatic bus_access(input logic [31:0] addr, input logic [3:0] wstrb,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        @(negedge ck);
        req = '{valid: 1'b1, wstrb: wstrb, addr: addr, wdata: wdata};
        do begin
            @(negedge ck);
        end while (!rsp.ready);
        rdata = rsp.rdata;
        req = '0;
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        bus_access(addr, 4'hf, data, unused);
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        bus_access(addr, 4'h0, 32'h0, data);
    endtask

    task automatic expect_word(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            test_errors++;
            $display("FAILED %s expected %h actual %h", what, exp, act);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        errors += test_errors;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic write_frame(input logic [5:0] f);
        bus_write(BASE + REG_STATUS + 32'h4, {26'h0, f});
        m_frame = f;
    endtask

    task automatic write_sample(input int idx, input logic [15:0] v);
        bus_write(BASE + REG_AUDIO + 32'(idx * 4), {16'h0, v});
        m_audio[idx] = v;
    endtask

    task automatic load_program();
        foreach (prog[i]) begin
            bus_write(BASE + REG_COEF + 32'(i * 4), prog[i]);
            m_coef[i] = prog[i];
        end
    endtask

    // CLR, random body, both saves, HALT
    task automatic random_prog(input int len, input logic past_frame);
        logic [2:0]  kind;
        logic [3:0]  op;
        logic [2:0]  chan;
        logic [5:0]  off;
        logic        side;
        logic [13:0] g;
        prog.delete();
        prog.push_back(make_instr(OP_CLR, 3'd0, 6'd0, 1'b0, 16'h0));
        for (int i = 0; i < len; i++) begin
            kind = 3'(rand_bits(3));
            chan = 3'(rand_bits(3));
            off = 6'(rand_bits(6));
            side = 1'(rand_bits(1));
            g = 14'(rand_bits(14));
            if (past_frame && off <= m_frame) begin
                off = off + 6'd32;
            end
            op = (kind == 3'd4) ? OP_SAVE : (kind == 3'd5) ? OP_CLR :
                 (kind == 3'd6) ? OP_NOP : OP_MAC;
            prog.push_back(make_instr(op, chan, off, side, {{2{g[13]}}, g}));
        end
        prog.push_back(make_instr(OP_SAVE, 3'd0, 6'd0, 1'b0, 16'h0));
        prog.push_back(make_instr(OP_SAVE, 3'd0, 6'd0, 1'b1, 16'h0));
        prog.push_back(make_instr(OP_HALT, 3'd0, 6'd0, 1'b0, 16'h0));
    endtask

    task automatic run_program(input string name);
        logic [31:0] st;
        logic [31:0] val;
        int          polls;
        bus_write(BASE + REG_RUN, 32'h1);
        model_run();
        // first poll lands while the opening fetch is still going on
        bus_read(BASE + REG_STATUS, st);
        expect_word({name, " busy"}, 32'h4, st);
        polls = 1;
        while (st[1:0] == 2'b00 && polls < POLL_MAX) begin
            bus_read(BASE + REG_STATUS, st);
            polls++;
        end
        if (st[1:0] == 2'b00) begin
            $display("%s: run did not finish within %0d status polls", name, POLL_MAX);
            test_errors++;
        end
        expect_word({name, " status"}, {30'h0, m_error, m_done}, st);
        bus_read(BASE + REG_RESULT, val);
        expect_word({name, " left"}, {{16{m_left[15]}}, m_left}, val);
        bus_read(BASE + REG_RESULT + 32'h4, val);
        expect_word({name, " right"}, {{16{m_right[15]}}, m_right}, val);
    endtask

    initial begin
        repeat (WATCH_CK) @(posedge ck);
        $display("watchdog expired after %0d clock cycles", WATCH_CK);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        logic [31:0] rd;
        int          n;
        int          waited;
        ck = 1'b0;
        rst = 1'b1;
        req = '0;
        lfsr_state = SEED;
        errors = 0;
        checks = 0;
        test_errors = 0;
        tests_run = 0;
        m_frame = '0;
        m_left = '0;
        m_right = '0;
        repeat (2) @(posedge ck);
        @(negedge ck);
        rst = 1'b0;

        // register access after reset
        bus_read(BASE + REG_STATUS, rd);
        expect_word("regs status", 32'h0, rd);
        bus_read(BASE + REG_RESULT, rd);
        expect_word("regs left", 32'h0, rd);
        bus_read(BASE + REG_RESULT + 32'h4, rd);
        expect_word("regs right", 32'h0, rd);
        bus_read(BASE + REG_STATUS + 32'h4, rd);
        expect_word("regs frame reset", 32'h0, rd);
        write_frame(6'h2a);
        bus_read(BASE + REG_STATUS + 32'h4, rd);
        expect_word("regs frame", 32'h2a, rd);
        finish_test("regs");

        for (int i = 0; i < AUDIO; i++) begin
            write_sample(i, 16'(rand_bits(16)));
        end

        for (int r = 0; r < 8; r++) begin
            write_frame(6'(rand_bits(6)));
            random_prog(1 + int'(rand_bits(3)), 1'b0);
            load_program();
            run_program($sformatf("mix %0d", r));
        end
        finish_test("mix");

        // samples on channel 7, reached from frame 8 by offsets 0 to 3
        write_frame(6'd8);
        write_sample(7 * 64 + 8, 16'h7fff);
        write_sample(7 * 64 + 7, 16'h8000);
        write_sample(7 * 64 + 6, 16'h0001);
        write_sample(7 * 64 + 5, 16'hffff);
        prog.delete();
        prog.push_back(make_instr(OP_CLR, 3'd0, 6'd0, 1'b0, 16'h0));
        repeat (4) prog.push_back(make_instr(OP_MAC, 3'd7, 6'd0, 1'b0, 16'h7fff));
        prog.push_back(make_instr(OP_SAVE, 3'd0, 6'd0, 1'b0, 16'h0));
        prog.push_back(make_instr(OP_CLR, 3'd0, 6'd0, 1'b0, 16'h0));
        repeat (4) prog.push_back(make_instr(OP_MAC, 3'd7, 6'd1, 1'b0, 16'h7fff));
        prog.push_back(make_instr(OP_SAVE, 3'd0, 6'd0, 1'b1, 16'h0));
        prog.push_back(make_instr(OP_HALT, 3'd0, 6'd0, 1'b0, 16'h0));
        load_program();
        run_program("saturate");
        // exactly half an LSB either side of zero
        prog.delete();
        prog.push_back(make_instr(OP_CLR, 3'd0, 6'd0, 1'b0, 16'h0));
        prog.push_back(make_instr(OP_MAC, 3'd7, 6'd2, 1'b0, 16'h4000));
        prog.push_back(make_instr(OP_SAVE, 3'd0, 6'd0, 1'b0, 16'h0));
        prog.push_back(make_instr(OP_CLR, 3'd0, 6'd0, 1'b0, 16'h0));
        prog.push_back(make_instr(OP_MAC, 3'd7, 6'd3, 1'b0, 16'h4000));
        prog.push_back(make_instr(OP_SAVE, 3'd0, 6'd0, 1'b1, 16'h0));
        prog.push_back(make_instr(OP_HALT, 3'd0, 6'd0, 1'b0, 16'h0));
        load_program();
        run_program("round");
        finish_test("saturate_round");

        write_frame(6'd5);
        for (int r = 0; r < 3; r++) begin
            random_prog(2 + int'(rand_bits(3)), 1'b1);
            load_program();
            run_program($sformatf("wrap %0d", r));
        end
        finish_test("frame_wrap");

        // illegal word between the two saves
        prog.delete();
        prog.push_back(make_instr(OP_CLR, 3'd0, 6'd0, 1'b0, 16'h0));
        prog.push_back(make_instr(OP_MAC, 3'd0, 6'd0, 1'b0, 16'h2000));
        prog.push_back(make_instr(OP_SAVE, 3'd0, 6'd0, 1'b0, 16'h0));
        prog.push_back(make_instr(4'h9, 3'd0, 6'd0, 1'b0, 16'h0));
        prog.push_back(make_instr(OP_SAVE, 3'd0, 6'd0, 1'b1, 16'h0));
        prog.push_back(make_instr(OP_HALT, 3'd0, 6'd0, 1'b0, 16'h0));
        load_program();
        run_program("illegal");
        prog.delete();
        prog.push_back(make_instr(OP_CLR, 3'd0, 6'd0, 1'b0, 16'h0));
        prog.push_back(make_instr(OP_SAVE, 3'd0, 6'd0, 1'b1, 16'h0));
        prog.push_back(make_instr(OP_HALT, 3'd0, 6'd0, 1'b0, 16'h0));
        load_program();
        run_program("recover");
        finish_test("error");

        random_prog(6, 1'b0);
        load_program();
        run_program("i2s run");
        n = frames_seen;
        waited = 0;
        // the second new frame was latched after the run ended
        while (frames_seen < n + 2 && waited < 4 * FRAME_CK) begin
            @(negedge ck);
            waited++;
        end
        if (frames_seen < n + 2) begin
            $display("i2s: no complete frame decoded from sd within %0d cycles", waited);
            test_errors++;
        end
        if (bad_halves != 0) begin
            $display("i2s: %0d ws halves did not last %0d clock cycles",
                     bad_halves, FRAME_CK / 2);
            test_errors++;
        end
        expect_word("i2s left", {16'h0, m_left}, {16'h0, cap_left});
        expect_word("i2s right", {16'h0, m_right}, {16'h0, cap_right});
        finish_test("i2s");

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* audio_engine.f */
+incdir+test
common/audio_pkg.sv
common/seq_pkg.sv
design/dpram.sv
design/bus_regs.sv
sequencer/sequencer.sv
sequencer/mac_unit.sv
i2s/i2s_out.sv
design/audio_engine.sv
test/tb_audio_engine.sv

/* run.sh */
#!/usr/bin/env bash
# build the audio engine testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -j 0 \
    -f audio_engine.f --top-module tb_audio_engine \
    -Mdir obj_dir -o tb_audio_engine
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_audio_engine)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1
